// File: include/tcdm_xbar_cfg.svh
/*
  crossbar sizing, shared by the package and all RTL
  bank count and bank depth must be powers of two, at least two cores
*/
`ifndef TCDM_XBAR_CFG_SVH
`define TCDM_XBAR_CFG_SVH

// request ports
`define TCDM_N_CORES 4

// memory banks, word interleaved
`define TCDM_N_BANKS 4

// word and byte address widths
`define TCDM_DATA_W 32
`define TCDM_ADDR_W 16

// words per bank
`define TCDM_BANK_DEPTH 64

`endif

// File: src/tcdm_xbar_pkg.sv
/*
  types shared by the crossbar, its banks and the configuration block
  widths follow the macros in the cfg header
*/
`include "tcdm_xbar_cfg.svh"

package tcdm_xbar_pkg;

  typedef logic [`TCDM_DATA_W-1:0]                data_t;
  typedef logic [`TCDM_ADDR_W-1:0]                addr_t;
  typedef logic [`TCDM_DATA_W/8-1:0]              be_t;
  typedef logic [$clog2(`TCDM_N_CORES)-1:0]       core_idx_t;
  typedef logic [$clog2(`TCDM_N_BANKS)-1:0]       bank_idx_t;
  typedef logic [$clog2(`TCDM_BANK_DEPTH)-1:0]    row_t;
  typedef logic [15:0]                            cnt_t;

  // core 0 has the highest priority in fixed mode
  typedef enum logic {
    ARB_ROUND_ROBIN = 1'b0,
    ARB_FIXED_PRIO  = 1'b1
  } arb_policy_e;

  // request payload from a core, held stable until gnt
  typedef struct packed {
    logic  wen;    // 1 = write
    addr_t addr;
    data_t wdata;
    be_t   be;
  } core_req_t;

  typedef struct packed {
    logic  r_valid;
    data_t r_data; // zero on write responses
  } core_resp_t;

  // granted request as seen by one bank
  typedef struct packed {
    logic  req;
    logic  wen;
    row_t  row;
    data_t wdata;
    be_t   be;
  } bank_req_t;

endpackage

// File: src/tcdm_xbar_ctrl_regs.sv
/*
  policy register at address 0, conflict counter at address 1
  a write to address 1 clears the counter, it saturates at all ones
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_xbar_ctrl_regs import tcdm_xbar_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cfg_we_i,
  input  logic                       cfg_addr_i,
  input  data_t                      cfg_wdata_i,
  output data_t                      cfg_rdata_o,
  input  logic [`TCDM_N_CORES-1:0]   core_req_i,
  input  logic [`TCDM_N_CORES-1:0]   core_gnt_i,
  output arb_policy_e                policy_o
);

  localparam int unsigned WAIT_W = $clog2(`TCDM_N_CORES + 1);
  localparam int unsigned SUM_W  = $bits(cnt_t) + 1;

  typedef logic [WAIT_W-1:0] wait_t;
  typedef logic [SUM_W-1:0]  sum_t;

  arb_policy_e policy_q;
  cnt_t        cnt_q;
  wait_t       n_wait;
  sum_t        cnt_sum;

  // cores stalled this cycle
  always_comb begin
    n_wait = '0;
    for (int i = 0; i < `TCDM_N_CORES; i++) begin
      n_wait = n_wait + wait_t'(core_req_i[i] & ~core_gnt_i[i]);
    end
  end

  assign cnt_sum = {1'b0, cnt_q} + sum_t'(n_wait);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      policy_q <= ARB_ROUND_ROBIN;
      cnt_q    <= '0;
    end else begin
      if (cfg_we_i && !cfg_addr_i) policy_q <= arb_policy_e'(cfg_wdata_i[0]);
      if (cfg_we_i && cfg_addr_i) begin
        cnt_q <= '0; // clear wins over this cycle's conflicts
      end else begin
        cnt_q <= cnt_sum[SUM_W-1] ? '1 : cnt_sum[SUM_W-2:0];
      end
    end
  end

  assign cfg_rdata_o = cfg_addr_i ? data_t'(cnt_q) : data_t'(policy_q);
  assign policy_o    = policy_q;

endmodule

// File: src/tcdm_bank_arbiter.sv
/*
  arbiter and request mux for one bank, fully combinational grant
  bank select sits just above the byte offset, row bits above that
  the round-robin pointer also advances while fixed priority is active
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_bank_arbiter import tcdm_xbar_pkg::*; #(
  parameter int unsigned BANK_IDX = 0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  arb_policy_e                  policy_i,
  input  logic      [`TCDM_N_CORES-1:0] core_req_i,
  input  core_req_t [`TCDM_N_CORES-1:0] core_data_i,
  output logic      [`TCDM_N_CORES-1:0] gnt_o,
  output bank_req_t                    bank_o,
  output core_idx_t                    winner_o
);

  localparam int unsigned N_CORES  = `TCDM_N_CORES;
  localparam int unsigned BANK_LSB = $clog2(`TCDM_DATA_W / 8);
  localparam int unsigned BANK_W   = $bits(bank_idx_t);
  localparam int unsigned ROW_LSB  = BANK_LSB + BANK_W;
  localparam int unsigned ROW_W    = $bits(row_t);

  logic [N_CORES-1:0] match;
  logic               found;
  core_idx_t          winner;
  core_idx_t          rr_ptr_q;
  core_req_t          sel;

  // requests aimed at this bank
  always_comb begin
    for (int i = 0; i < N_CORES; i++) begin
      match[i] = core_req_i[i] &&
                 (core_data_i[i].addr[BANK_LSB +: BANK_W] == bank_idx_t'(BANK_IDX));
    end
  end

  // first match in search order, which starts at 0 or at the pointer
  always_comb begin : pick
    int unsigned cand;
    found  = 1'b0;
    winner = '0;
    for (int k = 0; k < N_CORES; k++) begin
      if (policy_i == ARB_FIXED_PRIO) begin
        cand = k;
      end else begin
        cand = (int'(rr_ptr_q) + k) % N_CORES;
      end
      if (!found && match[cand]) begin
        found  = 1'b1;
        winner = core_idx_t'(cand);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (found) gnt_o[winner] = 1'b1;
  end

  // pointer moves to the core after the winner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (found) begin
      if (int'(winner) == N_CORES - 1) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= winner + 1'b1;
      end
    end
  end

  assign sel = core_data_i[winner];

  always_comb begin
    bank_o.req   = found;
    bank_o.wen   = sel.wen;
    bank_o.row   = sel.addr[ROW_LSB +: ROW_W]; // high bits above the row ignored
    bank_o.wdata = sel.wdata;
    bank_o.be    = sel.be;
  end

  assign winner_o = winner;

endmodule

// File: src/tcdm_resp_router.sv
/*
  response path, one cycle behind the grant
  each core wins at most one bank per cycle, so bank results are ORed per core
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_resp_router import tcdm_xbar_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic       [`TCDM_N_BANKS-1:0] bank_req_i,
  input  logic       [`TCDM_N_BANKS-1:0] bank_wen_i,
  input  core_idx_t  [`TCDM_N_BANKS-1:0] winner_i,
  input  data_t      [`TCDM_N_BANKS-1:0] bank_rdata_i,
  output core_resp_t [`TCDM_N_CORES-1:0] core_resp_o
);

  localparam int unsigned N_BANKS = `TCDM_N_BANKS;
  localparam int unsigned N_CORES = `TCDM_N_CORES;

  logic      [N_BANKS-1:0] valid_q;
  logic      [N_BANKS-1:0] read_q;
  core_idx_t [N_BANKS-1:0] winner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= bank_req_i;
    end
  end

  // owner and access type of last cycle's bank access
  always_ff @(posedge clk_i) begin
    winner_q <= winner_i;
    read_q   <= ~bank_wen_i;
  end

  always_comb begin
    for (int c = 0; c < N_CORES; c++) begin
      core_resp_o[c] = '0;
      for (int b = 0; b < N_BANKS; b++) begin
        if (valid_q[b] && winner_q[b] == core_idx_t'(c)) begin
          core_resp_o[c].r_valid = 1'b1;
          if (read_q[b]) begin
            core_resp_o[c].r_data = core_resp_o[c].r_data | bank_rdata_i[b];
          end
        end
      end
    end
  end

endmodule

// File: src/tcdm_bank_mem.sv
/*
  behavioural single-port bank, contents undefined after reset
  write at the clock edge, read data registered and valid next cycle
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_bank_mem import tcdm_xbar_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t bank_i,
  output data_t     rdata_o
);

  localparam int unsigned N_BYTES = `TCDM_DATA_W / 8;
  localparam int unsigned DEPTH   = `TCDM_BANK_DEPTH;

  data_t mem_q [DEPTH];
  data_t rdata_q;
  logic  do_write;
  logic  do_read;

  assign do_write = bank_i.req &  bank_i.wen;
  assign do_read  = bank_i.req & ~bank_i.wen;

  // byte-enabled write, disabled lanes keep their contents
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int b = 0; b < N_BYTES; b++) begin
        if (bank_i.be[b]) begin
          mem_q[bank_i.row][8*b +: 8] <= bank_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // read port, holds its value between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (do_read) begin
      rdata_q <= mem_q[bank_i.row];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: src/tcdm_xbar_top.sv
/*
  word-interleaved crossbar with behavioural banks
  one response per grant, exactly one cycle later, no back-pressure on responses
  policy changes take effect one cycle after the configuration write
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_xbar_top import tcdm_xbar_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic       [`TCDM_N_CORES-1:0] core_req_i,
  input  core_req_t  [`TCDM_N_CORES-1:0] core_data_i,
  output logic       [`TCDM_N_CORES-1:0] core_gnt_o,
  output core_resp_t [`TCDM_N_CORES-1:0] core_resp_o,
  input  logic                           cfg_we_i,
  input  logic                           cfg_addr_i,
  input  data_t                          cfg_wdata_i,
  output data_t                          cfg_rdata_o
);

  localparam int unsigned N_BANKS = `TCDM_N_BANKS;
  localparam int unsigned N_CORES = `TCDM_N_CORES;

  arb_policy_e                     policy;
  logic      [N_BANKS-1:0][N_CORES-1:0] bank_gnt; // per bank, one bit per core
  bank_req_t [N_BANKS-1:0]         bank_req;
  core_idx_t [N_BANKS-1:0]         bank_winner;
  data_t     [N_BANKS-1:0]         bank_rdata;
  logic      [N_BANKS-1:0]         bank_req_vld;
  logic      [N_BANKS-1:0]         bank_wen;

  tcdm_xbar_ctrl_regs i_ctrl_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .core_req_i  ( core_req_i  ),
    .core_gnt_i  ( core_gnt_o  ),
    .policy_o    ( policy      )
  );

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    tcdm_bank_arbiter #(
      .BANK_IDX ( b )
    ) i_arbiter (
      .clk_i       ( clk_i          ),
      .rst_ni      ( rst_ni         ),
      .policy_i    ( policy         ),
      .core_req_i  ( core_req_i     ),
      .core_data_i ( core_data_i    ),
      .gnt_o       ( bank_gnt[b]    ),
      .bank_o      ( bank_req[b]    ),
      .winner_o    ( bank_winner[b] )
    );

    tcdm_bank_mem i_mem (
      .clk_i   ( clk_i         ),
      .rst_ni  ( rst_ni        ),
      .bank_i  ( bank_req[b]   ),
      .rdata_o ( bank_rdata[b] )
    );

    assign bank_req_vld[b] = bank_req[b].req;
    assign bank_wen[b]     = bank_req[b].wen;
  end

  // a core targets one address, so at most one bank grants it
  always_comb begin
    core_gnt_o = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      core_gnt_o = core_gnt_o | bank_gnt[b];
    end
  end

  tcdm_resp_router i_resp_router (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .bank_req_i   ( bank_req_vld ),
    .bank_wen_i   ( bank_wen     ),
    .winner_i     ( bank_winner  ),
    .bank_rdata_i ( bank_rdata   ),
    .core_resp_o  ( core_resp_o  )
  );

endmodule

// File: testbench/tcdm_xbar_chk.sv
/*
  grant and response protocol assertions, bound into tcdm_xbar_top
  bank ownership is decoded from the request addresses at the core ports
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_xbar_chk import tcdm_xbar_pkg::*; (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic       [`TCDM_N_CORES-1:0] req_i,
  input core_req_t  [`TCDM_N_CORES-1:0] data_i,
  input logic       [`TCDM_N_CORES-1:0] gnt_i,
  input core_resp_t [`TCDM_N_CORES-1:0] resp_i
);

  localparam int unsigned BANK_LSB = $clog2(`TCDM_DATA_W / 8);
  localparam int unsigned BANK_W   = $bits(bank_idx_t);

  for (genvar c = 0; c < `TCDM_N_CORES; c++) begin : g_core
    // both ways, so a stray r_valid fails too
    a_resp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_i[c].r_valid == $past(gnt_i[c]))
      else $error("core %0d: r_valid does not follow its grant by one cycle", c);
  end

  for (genvar b = 0; b < `TCDM_N_BANKS; b++) begin : g_bank
    logic [`TCDM_N_CORES-1:0] gnt_here; // granted cores aimed at this bank

    for (genvar c = 0; c < `TCDM_N_CORES; c++) begin : g_core
      assign gnt_here[c] = gnt_i[c] &&
                           (data_i[c].addr[BANK_LSB +: BANK_W] == bank_idx_t'(b));
    end

    a_one_winner: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_here))
      else $error("bank %0d grants more than one core", b);
  end

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_i & ~req_i) == '0)
    else $error("grant given to a core that does not request");

endmodule

// File: testbench/tcdm_xbar_tb.sv
/*
  self-checking testbench for tcdm_xbar_top, reference memory ordered by grant
  banks are filled first since bank contents are undefined after reset
  arbitration is predicted for every grant from the tracked per-bank winner
*/
`timescale 1ns/1ps
`include "tcdm_xbar_cfg.svh"

module tcdm_xbar_tb import tcdm_xbar_pkg::*; ();

  localparam int N_CORES     = `TCDM_N_CORES;
  localparam int N_BANKS     = `TCDM_N_BANKS;
  localparam int DEPTH       = `TCDM_BANK_DEPTH;
  localparam int N_BYTES     = `TCDM_DATA_W / 8;
  localparam int CLK_PERIOD  = 40;
  localparam int RAND_CYCLES = 500;
  localparam int TEST_CYCLES = 2 * RAND_CYCLES + DEPTH + 200;

  logic                       clk_i;
  logic                       rst_ni;
  logic       [N_CORES-1:0]   core_req;
  core_req_t  [N_CORES-1:0]   core_data;
  logic       [N_CORES-1:0]   core_gnt;
  core_resp_t [N_CORES-1:0]   core_resp;
  logic                       cfg_we;
  logic                       cfg_addr;
  data_t                      cfg_wdata;
  data_t                      cfg_rdata;

  logic [31:0] lfsr_q;
  data_t       ref_mem [N_BANKS][DEPTH];
  data_t       exp_q [N_CORES][$];         // expected response per core
  core_idx_t   last_win [N_BANKS];
  arb_policy_e policy_ref;
  int          conflicts;

  tcdm_xbar_top uut (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .core_req_i  ( core_req  ),
    .core_data_i ( core_data ),
    .core_gnt_o  ( core_gnt  ),
    .core_resp_o ( core_resp ),
    .cfg_we_i    ( cfg_we    ),
    .cfg_addr_i  ( cfg_addr  ),
    .cfg_wdata_i ( cfg_wdata ),
    .cfg_rdata_o ( cfg_rdata )
  );

  bind tcdm_xbar_top tcdm_xbar_chk i_chk (
    .clk_i  ( clk_i       ),
    .rst_ni ( rst_ni      ),
    .req_i  ( core_req_i  ),
    .data_i ( core_data_i ),
    .gnt_i  ( core_gnt_o  ),
    .resp_i ( core_resp_o )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic compare_data(input string name, input data_t act, input data_t exp);
    if (act !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, name, act, exp));
    end
  endtask

  task automatic compare_cnt(input string name, input cnt_t act, input cnt_t exp);
    if (act !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, act, exp));
    end
  endtask

  task automatic compare_idx(input string name, input core_idx_t act, input core_idx_t exp);
    if (act !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, act, exp));
    end
  endtask

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic core_req_t random_req();
    core_req_t r;
    r.wen   = rand_bits(1) != 0;
    r.addr  = addr_t'(rand_bits($bits(addr_t)));  // high bits are don't care
    r.wdata = data_t'(rand_bits($bits(data_t)));
    r.be    = be_t'(rand_bits($bits(be_t)));
    return r;
  endfunction

  // word interleaving: byte offset 1:0, then bank, then row
  function automatic bank_idx_t bank_of(input addr_t a);
    return bank_idx_t'(a >> 2);
  endfunction

  function automatic row_t row_of(input addr_t a);
    return row_t'(a >> (2 + $bits(bank_idx_t)));
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return {a ^ 16'h3c5a, ~a};
  endfunction

  // reference for one granted access, returns the expected r_data
  function automatic data_t ref_access(input core_req_t r);
    data_t word;
    word = ref_mem[bank_of(r.addr)][row_of(r.addr)];
    if (!r.wen) return word;
    for (int i = 0; i < N_BYTES; i++) begin
      if (r.be[i]) word[8*i +: 8] = r.wdata[8*i +: 8];
    end
    ref_mem[bank_of(r.addr)][row_of(r.addr)] = word;
    return '0;
  endfunction

  function automatic logic targets(input int c, input int b);
    return core_req[c] && (int'(bank_of(core_data[c].addr)) == b);
  endfunction

  function automatic cnt_t expected_count();
    if (conflicts >= (1 << $bits(cnt_t))) return '1; // counter saturates
    return cnt_t'(conflicts);
  endfunction

  function automatic int pending_responses();
    int n;
    n = 0;
    for (int c = 0; c < N_CORES; c++) n += exp_q[c].size();
    return n;
  endfunction

  // predicted winner per bank from policy and last winner
  task automatic check_arbitration();
    logic      found;
    logic      granted;
    core_idx_t exp_win;
    core_idx_t act_win;
    int        c;
    if ((core_gnt & ~core_req) != '0) stop_with_failure("a core was granted without a request");
    for (int b = 0; b < N_BANKS; b++) begin
      found   = 1'b0;
      granted = 1'b0;
      exp_win = '0;
      act_win = '0;
      for (int k = 0; k < N_CORES; k++) begin
        c = (policy_ref == ARB_FIXED_PRIO) ? k : (int'(last_win[b]) + 1 + k) % N_CORES;
        if (!found && targets(c, b)) begin
          found   = 1'b1;
          exp_win = core_idx_t'(c);
        end
        if (core_gnt[k] && targets(k, b)) begin
          if (granted) begin
            stop_with_failure($sformatf("bank %0d granted more than one core", b));
          end else begin
            granted = 1'b1;
            act_win = core_idx_t'(k);
          end
        end
      end
      if (found != granted) begin
        stop_with_failure($sformatf("bank %0d: request present %0b but grant given %0b",
                                    b, found, granted));
      end else if (found) begin
        compare_idx($sformatf("winner of bank %0d", b), act_win, exp_win);
        last_win[b] = act_win;
      end
    end
  endtask

  // compare process, responses first, then this edge's grants
  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int c = 0; c < N_CORES; c++) begin
        if (core_resp[c].r_valid) begin
          if (exp_q[c].size() == 0) begin
            stop_with_failure($sformatf("core %0d got r_valid without a grant", c));
          end else begin
            compare_data($sformatf("core_resp_o[%0d].r_data", c), core_resp[c].r_data,
                         exp_q[c].pop_front());
          end
        end else if (exp_q[c].size() != 0) begin
          stop_with_failure($sformatf("core %0d got no r_valid one cycle after its grant", c));
        end
      end
      check_arbitration();
      for (int c = 0; c < N_CORES; c++) begin
        if (core_gnt[c]) exp_q[c].push_back(ref_access(core_data[c]));
        if (core_req[c] && !core_gnt[c]) conflicts++;
      end
    end
  end

  task automatic cfg_write(input logic addr, input data_t data);
    @(posedge clk_i);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk_i);
    cfg_we <= 1'b0;
    if (!addr) policy_ref <= arb_policy_e'(data[0]); // applies from the next grant
    else conflicts = 0;
  endtask

  task automatic cfg_read(input logic addr, output data_t val);
    @(posedge clk_i);
    cfg_addr <= addr;
    @(posedge clk_i);
    val = cfg_rdata;
  endtask

  // all four cores write rows in parallel, core c to bank c
  task automatic fill_banks();
    core_req_t r;
    @(posedge clk_i);
    for (int row = 0; row < DEPTH; row++) begin
      for (int c = 0; c < N_CORES; c++) begin
        r.wen        = 1'b1;
        r.addr       = addr_t'(((row << $bits(bank_idx_t)) | c) << 2);
        r.wdata      = fill_word(r.addr);
        r.be         = '1;
        core_data[c] <= r;
        core_req[c]  <= 1'b1;
      end
      @(posedge clk_i);
      if (core_gnt != '1) stop_with_failure("cores on distinct banks were not all granted");
    end
    core_req <= '0;
    @(posedge clk_i);
  endtask

  // hold ungranted requests until they win, then one cycle for responses
  task automatic drain_requests();
    logic [N_CORES-1:0] left;
    do begin
      @(posedge clk_i);
      left = core_req & ~core_gnt;
      core_req <= left;
    end while (left != '0);
    @(posedge clk_i);
  endtask

  task automatic run_random(input int n_cycles);
    repeat (n_cycles) begin
      @(posedge clk_i);
      for (int c = 0; c < N_CORES; c++) begin
        if (!core_req[c] || core_gnt[c]) begin
          if (rand_bits(2) != 0) begin // idle one time in four
            core_data[c] <= random_req();
            core_req[c]  <= 1'b1;
          end else begin
            core_req[c] <= 1'b0;
          end
        end
      end
    end
    drain_requests();
  endtask

  // every core keeps requesting one bank until its quota is granted
  task automatic run_same_bank(input bank_idx_t bank, input int per_core);
    int        left [N_CORES];
    logic      busy;
    core_req_t r;
    foreach (left[c]) left[c] = per_core;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk_i);
      busy = 1'b0;
      for (int c = 0; c < N_CORES; c++) begin
        if (core_req[c] && !core_gnt[c]) begin
          busy = 1'b1;
        end else if (left[c] > 0) begin
          r = random_req();
          r.addr[2 +: $bits(bank_idx_t)] = bank;
          core_data[c] <= r;
          core_req[c]  <= 1'b1;
          left[c]--;
          busy = 1'b1;
        end else begin
          core_req[c] <= 1'b0;
        end
      end
    end
    @(posedge clk_i);
  endtask

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 4);
    stop_with_failure("watchdog expired before the test finished");
  end

  initial begin : main
    data_t rd;
    lfsr_q     = 32'h0c6e_0677;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    core_req   = '0;
    core_data  = '0;
    cfg_we     = 1'b0;
    cfg_addr   = 1'b0;
    cfg_wdata  = '0;
    policy_ref = ARB_ROUND_ROBIN;
    conflicts  = 0;
    for (int b = 0; b < N_BANKS; b++) last_win[b] = core_idx_t'(N_CORES - 1); // pointer 0
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    fill_banks();
    run_random(RAND_CYCLES);
    run_same_bank(bank_idx_t'(2), 3);

    cfg_write(1'b0, data_t'(ARB_FIXED_PRIO));
    cfg_read(1'b0, rd);
    compare_data("policy register", rd, data_t'(ARB_FIXED_PRIO));
    run_random(RAND_CYCLES);
    run_same_bank(bank_idx_t'(1), 3);

    cfg_read(1'b1, rd);
    compare_cnt("conflict counter", cnt_t'(rd), expected_count());
    cfg_write(1'b1, '0);
    cfg_read(1'b1, rd);
    compare_cnt("conflict counter after clear", cnt_t'(rd), expected_count());

    @(posedge clk_i);
    if (pending_responses() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_with_failure("responses still outstanding at the end of the test");
    end
  end

endmodule

// File: tcdm_xbar.f
+incdir+include
src/tcdm_xbar_pkg.sv
src/tcdm_xbar_ctrl_regs.sv
src/tcdm_bank_arbiter.sv
src/tcdm_resp_router.sv
src/tcdm_bank_mem.sv
src/tcdm_xbar_top.sv
testbench/tcdm_xbar_chk.sv
testbench/tcdm_xbar_tb.sv

// File: Makefile
# Verilator build and run of the crossbar testbench

TOP := tcdm_xbar_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tcdm_xbar.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
